// ==== verilog/yuv_rgb_pkg.sv ====
package yuv_rgb_pkg;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_word_t;
	typedef logic [7:0] sample_t;
	typedef logic signed [31:0] mac_t;
	typedef logic [7:0] pair_count_t;

	// bus action requested for the next cycle
	typedef enum logic [2:0] {
		op_none,
		op_read_y,
		op_read_u,
		op_read_v,
		op_write
	} sram_op_t;

	typedef enum logic [1:0] {
		cap_none,
		cap_y,
		cap_u,
		cap_v
	} capture_t;

	typedef struct packed {
		sram_op_t sram_op;
		capture_t capture;
		logic [2:0] mac_step; // 0..4, 7 when no multiply runs
		logic frame_begin;
	} csc_ctrl_t;

	localparam logic [2:0] mac_idle = 3'd7;

	// 16.16 fixed point colour matrix
	localparam mac_t coef_a00 = 32'sd76284;
	localparam mac_t coef_a02 = 32'sd104595;
	localparam mac_t coef_a11 = -32'sd25624;
	localparam mac_t coef_a12 = -32'sd53281;
	localparam mac_t coef_a21 = 32'sd132251;

	localparam mac_t y_offset = 32'sd16;
	localparam mac_t uv_offset = 32'sd128;

	// small frame for simulation
	localparam pair_count_t frame_pairs = 8'd8;
	localparam int unsigned pair_cycles = 12;

	localparam sram_addr_t y_base = 18'h00000;
	localparam sram_addr_t u_base = 18'h00100;
	localparam sram_addr_t v_base = 18'h00200;
	localparam sram_addr_t rgb_base = 18'h00300;

endpackage

// ==== verilog/pair_sequencer.sv ====
`timescale 1ns/1ps

module pair_sequencer (
	input logic clock,
	input logic resetn,
	input logic start,
	output yuv_rgb_pkg::csc_ctrl_t ctrl,
	output logic finish
);

	import yuv_rgb_pkg::*;

	typedef enum logic [1:0] {
		seq_idle,
		seq_fetch,
		seq_convert,
		seq_done
	} seq_state_t;

	localparam logic [3:0] last_slot = 4'(pair_cycles - 1);

	seq_state_t state;
	logic [3:0] slot;
	pair_count_t pair;

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			state <= seq_idle;
			slot <= 4'd0;
			pair <= '0;
			finish <= 1'b0;
		end else begin
			finish <= (state == seq_done);
			case (state)
				seq_idle: begin
					if (start) begin
						state <= seq_fetch;
						slot <= 4'd0;
						pair <= '0;
					end
				end
				seq_fetch: begin
					slot <= slot + 4'd1;
					if (slot == 4'd5)
						state <= seq_convert; // all three words captured
				end
				seq_convert: begin
					if (slot == last_slot) begin
						slot <= 4'd0;
						if (pair == frame_pairs - 8'd1) begin
							state <= seq_done;
						end else begin
							pair <= pair + 8'd1;
							state <= seq_fetch;
						end
					end else begin
						slot <= slot + 4'd1;
					end
				end
				default: state <= seq_idle; // last write on the bus
			endcase
		end
	end

	always_comb begin
		ctrl = '{sram_op: op_none, capture: cap_none, mac_step: mac_idle, frame_begin: 1'b0};
		case (state)
			seq_idle: ctrl.frame_begin = start;
			seq_fetch: begin
				case (slot)
					4'd0: ctrl.sram_op = op_read_y;
					4'd1: ctrl.sram_op = op_read_u;
					4'd2: ctrl.sram_op = op_read_v;
					4'd3: ctrl.capture = cap_y; // data of slot 0 read
					4'd4: ctrl.capture = cap_u;
					4'd5: ctrl.capture = cap_v;
					default: ctrl.capture = cap_none;
				endcase
			end
			seq_convert: begin
				if (slot <= 4'd10)
					ctrl.mac_step = 3'(slot - 4'd6);
				if (slot >= 4'd9)
					ctrl.sram_op = op_write;
			end
			default: ctrl.sram_op = op_none;
		endcase
	end

endmodule

// ==== verilog/sram_address_gen.sv ====
`timescale 1ns/1ps

module sram_address_gen (
	input logic clock,
	input logic resetn,
	input yuv_rgb_pkg::csc_ctrl_t ctrl,
	output yuv_rgb_pkg::sram_addr_t sram_address,
	output logic sram_we_n
);

	import yuv_rgb_pkg::*;

	sram_addr_t ptr_y, ptr_u, ptr_v, ptr_rgb;

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			sram_address <= '0;
			sram_we_n <= 1'b1;
			ptr_y <= y_base;
			ptr_u <= u_base;
			ptr_v <= v_base;
			ptr_rgb <= rgb_base;
		end else begin
			sram_we_n <= (ctrl.sram_op != op_write);
			if (ctrl.frame_begin) begin
				ptr_y <= y_base;
				ptr_u <= u_base;
				ptr_v <= v_base;
				ptr_rgb <= rgb_base;
			end
			case (ctrl.sram_op)
				op_read_y: begin
					sram_address <= ptr_y;
					ptr_y <= ptr_y + 18'd1;
				end
				op_read_u: begin
					sram_address <= ptr_u;
					ptr_u <= ptr_u + 18'd1;
				end
				op_read_v: begin
					sram_address <= ptr_v;
					ptr_v <= ptr_v + 18'd1;
				end
				op_write: begin
					sram_address <= ptr_rgb;
					ptr_rgb <= ptr_rgb + 18'd1;
				end
				default: sram_address <= sram_address; // bus holds last address
			endcase
		end
	end

endmodule

// ==== verilog/csc_datapath.sv ====
`timescale 1ns/1ps

module csc_datapath (
	input logic clock,
	input logic resetn,
	input yuv_rgb_pkg::csc_ctrl_t ctrl,
	input yuv_rgb_pkg::sram_word_t sram_read_data,
	output yuv_rgb_pkg::sram_word_t sram_write_data
);

	import yuv_rgb_pkg::*;

	sample_t y_s [2];
	sample_t u_s [2];
	sample_t v_s [2];
	mac_t acc_r [2];
	mac_t acc_g [2];
	mac_t acc_b [2];

	mac_t op_a, op_b, op_c, op_d;
	mac_t mult_1, mult_2;
	logic pix; // pixel served by the chroma steps

	logic [1:0] wr_count;
	logic [1:0] wr_sel;
	logic wr_active;
	sample_t r_o [2];
	sample_t g_o [2];
	sample_t b_o [2];

	function automatic mac_t centred(input sample_t s, input mac_t offset);
		centred = mac_t'({24'd0, s}) - offset;
	endfunction

	function automatic sample_t clip(input mac_t v);
		if (v[31])
			clip = 8'd0;
		else if (|v[30:24])
			clip = 8'd255;
		else
			clip = v[23:16];
	endfunction

	// even pixel sits in the high byte
	always_ff @(posedge clock) begin
		case (ctrl.capture)
			cap_y: {y_s[0], y_s[1]} <= sram_read_data;
			cap_u: {u_s[0], u_s[1]} <= sram_read_data;
			cap_v: {v_s[0], v_s[1]} <= sram_read_data;
			default: y_s[0] <= y_s[0];
		endcase
	end

	assign pix = (ctrl.mac_step >= 3'd3);

	// step 0 luma for both pixels, odd steps V, even steps U
	always_comb begin
		op_a = '0;
		op_b = '0;
		op_c = '0;
		op_d = '0;
		case (ctrl.mac_step)
			3'd0: begin
				op_a = centred(y_s[0], y_offset);
				op_b = coef_a00;
				op_c = centred(y_s[1], y_offset);
				op_d = coef_a00;
			end
			3'd1, 3'd3: begin
				op_a = centred(v_s[pix], uv_offset);
				op_b = coef_a02;
				op_c = op_a;
				op_d = coef_a12;
			end
			3'd2, 3'd4: begin
				op_a = centred(u_s[pix], uv_offset);
				op_b = coef_a11;
				op_c = op_a;
				op_d = coef_a21;
			end
			default: op_a = '0;
		endcase
	end

	assign mult_1 = op_a * op_b;
	assign mult_2 = op_c * op_d;

	always_ff @(posedge clock) begin
		case (ctrl.mac_step)
			3'd0: begin
				acc_r[0] <= mult_1;
				acc_g[0] <= mult_1;
				acc_b[0] <= mult_1;
				acc_r[1] <= mult_2;
				acc_g[1] <= mult_2;
				acc_b[1] <= mult_2;
			end
			3'd1, 3'd3: begin
				acc_r[pix] <= acc_r[pix] + mult_1; // a02 v
				acc_g[pix] <= acc_g[pix] + mult_2; // a12 v
			end
			3'd2, 3'd4: begin
				acc_g[pix] <= acc_g[pix] + mult_1; // a11 u
				acc_b[pix] <= acc_b[pix] + mult_2; // a21 u
			end
			default: acc_r[0] <= acc_r[0];
		endcase
	end

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			wr_count <= 2'd0;
			wr_sel <= 2'd0;
			wr_active <= 1'b0;
		end else begin
			wr_active <= (ctrl.sram_op == op_write);
			if (ctrl.frame_begin)
				wr_count <= 2'd0;
			else if (ctrl.sram_op == op_write) begin
				wr_sel <= wr_count;
				wr_count <= (wr_count == 2'd2) ? 2'd0 : wr_count + 2'd1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			r_o[i] = clip(acc_r[i]);
			g_o[i] = clip(acc_g[i]);
			b_o[i] = clip(acc_b[i]);
		end
	end

	always_comb begin
		sram_write_data = '0;
		if (wr_active) begin
			case (wr_sel)
				2'd0: sram_write_data = {r_o[0], g_o[0]};
				2'd1: sram_write_data = {b_o[0], r_o[1]};
				default: sram_write_data = {g_o[1], b_o[1]};
			endcase
		end
	end

endmodule

// ==== verilog/yuv_to_rgb.sv ====
`timescale 1ns/1ps

module yuv_to_rgb (
	input logic clock,
	input logic resetn,
	input logic start,
	input yuv_rgb_pkg::sram_word_t sram_read_data,
	output yuv_rgb_pkg::sram_addr_t sram_address,
	output yuv_rgb_pkg::sram_word_t sram_write_data,
	output logic sram_we_n,
	output logic finish
);

	import yuv_rgb_pkg::*;

	csc_ctrl_t ctrl; // per-cycle control from the sequencer

	pair_sequencer u_sequencer (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.ctrl(ctrl),
		.finish(finish)
	);

	sram_address_gen u_addr (
		.clock(clock),
		.resetn(resetn),
		.ctrl(ctrl),
		.sram_address(sram_address),
		.sram_we_n(sram_we_n)
	);

	csc_datapath u_datapath (
		.clock(clock),
		.resetn(resetn),
		.ctrl(ctrl),
		.sram_read_data(sram_read_data),
		.sram_write_data(sram_write_data)
	);

endmodule

// ==== verif/sram_model.sv ====
`timescale 1ns/1ps

module sram_model (
	input logic clock,
	input logic resetn,
	input yuv_rgb_pkg::sram_addr_t sram_address,
	input yuv_rgb_pkg::sram_word_t sram_write_data,
	input logic sram_we_n,
	output yuv_rgb_pkg::sram_word_t sram_read_data
);

	import yuv_rgb_pkg::*;

	logic [7:0] mem [2048]; // 1024 words, even byte is the high half
	logic [10:0] byte_index;
	sram_word_t read_stage;

	assign byte_index = {sram_address[9:0], 1'b0};

	always @(posedge clock) begin
		if (!sram_we_n) begin
			mem[byte_index] <= sram_write_data[15:8];
			mem[byte_index | 11'd1] <= sram_write_data[7:0];
		end
	end

	// two stages give the two-cycle read latency
	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			read_stage <= '0;
			sram_read_data <= '0;
		end else begin
			read_stage <= {mem[byte_index], mem[byte_index | 11'd1]};
			sram_read_data <= read_stage;
		end
	end

	task automatic write_byte(input int byte_addr, input logic [7:0] value);
		mem[byte_addr[10:0]] <= value;
	endtask

endmodule

// ==== verif/rgb_checker.sv ====
`timescale 1ns/1ps

module rgb_checker (
	input logic clock,
	input logic resetn,
	input logic start,
	input yuv_rgb_pkg::sram_addr_t sram_address,
	input yuv_rgb_pkg::sram_word_t sram_write_data,
	input logic sram_we_n,
	input logic finish
);

	import yuv_rgb_pkg::*;

	localparam int frame_cycles = int'(frame_pairs) * int'(pair_cycles) + 2;
	localparam int frame_writes = 3 * int'(frame_pairs);

	sram_word_t expected_q [$];
	logic busy = 1'b0;
	int cycles = 0; // edges since start was sampled
	int writes = 0;
	int test_index = 0;
	string test_kind = "";
	int test_errors = 0;
	int error_count = 0;
	int tests_done = 0;
	int tests_failed = 0;

	function automatic logic [7:0] saturate(input int v);
		if (v < 0)
			return 8'd0;
		if (v >= (1 << 24))
			return 8'd255;
		return v[23:16];
	endfunction

	// 16.16 result of the colour matrix for one pixel, as {R,G,B}
	function automatic logic [23:0] rgb_of(input sample_t y, input sample_t u, input sample_t v);
		int c;
		int d;
		int e;
		c = int'(y) - y_offset;
		d = int'(u) - uv_offset;
		e = int'(v) - uv_offset;
		return {saturate(coef_a00 * c + coef_a02 * e),
			saturate(coef_a00 * c + coef_a11 * d + coef_a12 * e),
			saturate(coef_a00 * c + coef_a21 * d)};
	endfunction

	task automatic value_error(input string signal, input logic [31:0] expected,
			input logic [31:0] actual);
		error_count++;
		test_errors++;
		$display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, signal,
			expected, actual);
	endtask

	task automatic other_error(input string what);
		error_count++;
		test_errors++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	task automatic begin_test(input int index, input string kind);
		test_index = index;
		test_kind = kind;
		test_errors = 0;
		expected_q.delete();
	endtask

	task automatic expect_rgb(input logic [23:0] rgb0, input logic [23:0] rgb1);
		expected_q.push_back(rgb0[23:8]); // R0 G0
		expected_q.push_back({rgb0[7:0], rgb1[23:16]});
		expected_q.push_back(rgb1[15:0]);
	endtask

	task automatic expect_yuv(input sample_t y0, input sample_t u0, input sample_t v0,
			input sample_t y1, input sample_t u1, input sample_t v1);
		expect_rgb(rgb_of(y0, u0, v0), rgb_of(y1, u1, v1));
	endtask

	task automatic check_write();
		sram_addr_t want_addr;
		sram_word_t want_word;
		if (!busy) begin
			other_error("write on the SRAM bus while no frame is running");
			return;
		end
		want_addr = rgb_base + sram_addr_t'(writes);
		if (sram_address !== want_addr)
			value_error("sram_address", 32'(want_addr), 32'(sram_address));
		if (expected_q.size() == 0) begin
			other_error("frame wrote more words than it has pixels for");
		end else begin
			want_word = expected_q.pop_front();
			if (sram_write_data !== want_word)
				value_error("sram_write_data", 32'(want_word), 32'(sram_write_data));
		end
		writes++;
	endtask

	task automatic end_frame();
		if (!busy) begin
			other_error("finish pulsed while no frame was running");
			return;
		end
		if (cycles != frame_cycles)
			value_error("finish cycle", 32'(frame_cycles), 32'(cycles));
		if (writes != frame_writes)
			value_error("write count", 32'(frame_writes), 32'(writes));
		if (expected_q.size() != 0)
			other_error($sformatf("%0d expected words were never written", expected_q.size()));
		if (test_errors == 0)
			$display("test %0d (%s): %0d writes, passed", test_index, test_kind, writes);
		else
			$display("test %0d (%s): %0d errors, failed", test_index, test_kind, test_errors);
		tests_done++;
		if (test_errors != 0)
			tests_failed++;
		busy = 1'b0;
	endtask

	task automatic print_counts(input int tests_expected);
		if (tests_done != tests_expected)
			other_error($sformatf("only %0d of %0d frames reached finish", tests_done,
				tests_expected));
		$display("tests run %0d, failed %0d, errors %0d", tests_done, tests_failed, error_count);
	endtask

	always @(posedge clock) begin
		if (resetn) begin
			if (busy)
				cycles++;
			if (!sram_we_n)
				check_write();
			if (finish)
				end_frame();
			if (start && !busy) begin
				busy = 1'b1; // DUT leaves idle on this edge
				cycles = 0;
				writes = 0;
			end
		end
	end

endmodule

// ==== verif/tb_yuv_to_rgb.sv ====
`timescale 1ns/1ps

module tb_yuv_to_rgb;

	import yuv_rgb_pkg::*;

	typedef struct packed {
		logic rnd; // pixels come from the generator
		sample_t y0;
		sample_t u0;
		sample_t v0;
		sample_t y1;
		sample_t u1;
		sample_t v1;
		logic [23:0] rgb0; // {R,G,B} of the even pixel
		logic [23:0] rgb1;
	} frame_entry_t;

	localparam int reset_cycles = 10;
	localparam int entry_count = 7;
	localparam int frame_limit = int'(frame_pairs) * int'(pair_cycles) + 20;

	logic clock;
	logic resetn;
	logic start;
	sram_word_t sram_read_data;
	sram_addr_t sram_address;
	sram_word_t sram_write_data;
	logic sram_we_n;
	logic finish;

	frame_entry_t frames [entry_count];
	logic [31:0] rng_state = 32'd83;

	yuv_to_rgb u_dut (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.sram_read_data(sram_read_data),
		.sram_address(sram_address),
		.sram_write_data(sram_write_data),
		.sram_we_n(sram_we_n),
		.finish(finish)
	);

	sram_model u_sram (
		.clock(clock),
		.resetn(resetn),
		.sram_address(sram_address),
		.sram_write_data(sram_write_data),
		.sram_we_n(sram_we_n),
		.sram_read_data(sram_read_data)
	);

	rgb_checker u_checker (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.sram_address(sram_address),
		.sram_write_data(sram_write_data),
		.sram_we_n(sram_we_n),
		.finish(finish)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// even pixel in the high byte of word p
	task automatic put_word(input sram_addr_t base, input int p, input sample_t even,
			input sample_t odd);
		u_sram.write_byte(2 * (int'(base) + p), even);
		u_sram.write_byte(2 * (int'(base) + p) + 1, odd);
	endtask

	task automatic load_frame(input frame_entry_t entry);
		sample_t px [6];
		for (int p = 0; p < int'(frame_pairs); p++) begin
			if (entry.rnd) begin
				rng_state = xorshift32(rng_state);
				px[0] = rng_state[7:0];
				px[1] = rng_state[15:8];
				px[2] = rng_state[23:16];
				rng_state = xorshift32(rng_state);
				px[3] = rng_state[7:0];
				px[4] = rng_state[15:8];
				px[5] = rng_state[23:16];
				u_checker.expect_yuv(px[0], px[1], px[2], px[3], px[4], px[5]);
			end else begin
				px = '{entry.y0, entry.u0, entry.v0, entry.y1, entry.u1, entry.v1};
				u_checker.expect_rgb(entry.rgb0, entry.rgb1);
			end
			put_word(y_base, p, px[0], px[3]);
			put_word(u_base, p, px[1], px[4]);
			put_word(v_base, p, px[2], px[5]);
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		repeat (reset_cycles + entry_count * frame_limit) @(posedge clock);
		$display("watchdog: frames did not all finish in time");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		string kind;
		// grey and black, then saturation, negative sums, red and near white
		frames[0] = '{1'b0, 8'd128, 8'd128, 8'd128, 8'd16, 8'd128, 8'd128, 24'h828282, 24'h000000};
		frames[1] = '{1'b0, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 24'hff7dff, 24'hff7dff};
		frames[2] = '{1'b0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 24'h008700, 24'h008700};
		frames[3] = '{1'b0, 8'd82, 8'd90, 8'd240, 8'd235, 8'd128, 8'd128, 24'hff0000, 24'hfefefe};
		for (int i = 4; i < entry_count; i++)
			frames[i] = '{1'b1, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 24'h0, 24'h0};
		start <= 1'b0;
		resetn <= 1'b0;
		repeat (reset_cycles) @(posedge clock);
		resetn <= 1'b1;
		repeat (2) @(posedge clock);
		for (int i = 0; i < entry_count; i++) begin
			if (frames[i].rnd)
				kind = "random";
			else
				kind = "hand-picked";
			u_checker.begin_test(i, kind);
			load_frame(frames[i]);
			@(posedge clock);
			start <= 1'b1;
			@(posedge clock);
			start <= 1'b0;
			do
				@(posedge clock);
			while (!finish);
			repeat (2) @(posedge clock);
		end
		u_checker.print_counts(entry_count);
		if (u_checker.error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== src.f ====
verilog/yuv_rgb_pkg.sv
verilog/pair_sequencer.sv
verilog/sram_address_gen.sv
verilog/csc_datapath.sv
verilog/yuv_to_rgb.sv
verif/sram_model.sv
verif/rgb_checker.sv
verif/tb_yuv_to_rgb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_yuv_to_rgb -f src.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_yuv_to_rgb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -Fqx "=== PASS ==="; then
	exit 0
fi
exit 1
